//--- Makefile
VERILATOR ?= verilator
TOP       := tb_ext_harness
FILE_LIST := verilog.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/ext_harness_chk.sv
/*
 * Bound checks on register bus errors and power switch acknowledges
 */
`timescale 1ns/10ps

module ext_harness_chk #(
  parameter int unsigned NumDomains       = 4,
  parameter int unsigned SwitchAckLatency = 15
) (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input logic                             reg_valid_i,
  input harness_pkg::addr_t               reg_addr_i,
  input harness_pkg::data_t               reg_rdata_i,
  input logic                             reg_error_i,
  input logic [harness_pkg::NUM_INTR-1:0] intr_i,
  input logic [NumDomains-1:0]            switch_n_i,
  input logic [NumDomains-1:0]            ack_n_i
);

  import harness_pkg::*;

  logic unmapped;

  assign unmapped = reg_valid_i && (reg_addr_i >= SCRATCH_BASE + PERIPH_WIN_SIZE);

  error_zero_data: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) reg_error_i |-> reg_rdata_i == '0
  ) else $error("Bus error returned nonzero read data");

  // Guarded until the delay line has seen a full latency of live inputs
  ack_latency: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i, SwitchAckLatency) |-> ack_n_i == $past(switch_n_i, SwitchAckLatency)
  ) else $error("Switch acknowledge does not follow its request");

  bus_err_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> intr_i[INTR_BUS_ERR] == $past(unmapped)
  ) else $error("Bus error interrupt not one cycle after the unmapped access");

endmodule

bind ext_harness ext_harness_chk #(
  .NumDomains       (NumDomains),
  .SwitchAckLatency (SwitchAckLatency)
) ext_harness_chk_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .reg_valid_i (reg_valid_i),
  .reg_addr_i  (reg_addr_i),
  .reg_rdata_i (reg_rdata_o),
  .reg_error_i (reg_error_o),
  .intr_i      (intr_o),
  .switch_n_i  (pwr_switch_n_i),
  .ack_n_i     (pwr_switch_ack_n_o)
);

//--- testbench/tb_ext_harness.sv
/*
 * Testbench for the harness subsystem: random bus, GPIO and power switch
 * stimulus compared each cycle against a reference model
 */
`timescale 1ns/10ps

module tb_ext_harness;

  import harness_pkg::*;

  localparam int unsigned CLK_PERIOD    = 40;
  localparam int unsigned RESET_CYCLES  = 10;
  localparam int unsigned CNT_MAX       = 16;
  localparam int unsigned NUM_DOMAINS   = 4;
  localparam int unsigned ACK_LATENCY   = 15;
  localparam int unsigned SCRATCH_OPS   = 300;
  localparam int unsigned GPIO_PULSES   = 40;
  localparam int unsigned UNMAPPED_OPS  = 50;
  localparam int unsigned PWR_CYCLES    = 200;
  localparam addr_t       UNMAPPED_BASE = 32'h0000_0200;
  // A GPIO pulse lasts at most 14 cycles
  localparam int unsigned MAX_CYCLES    = RESET_CYCLES + 6 + 2 * SCRATCH_OPS + 14 * GPIO_PULSES
                                          + 2 + 2 * UNMAPPED_OPS + PWR_CYCLES + 200;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_valid;
  logic                   reg_write;
  addr_t                  reg_addr;
  data_t                  reg_wdata;
  strb_t                  reg_wstrb;
  data_t                  reg_rdata;
  logic                   reg_error;
  logic                   gpio_in;
  logic                   gpio_out;
  logic [NUM_INTR-1:0]    intr;
  logic [NUM_DOMAINS-1:0] pwr_switch_n;
  logic [NUM_DOMAINS-1:0] pwr_switch_ack_n;

  logic [31:0]            rand_state;
  logic                   fail_seen;
  logic                   run_done;
  logic                   gpio_level;
  logic [NUM_DOMAINS-1:0] pwr_level;

  // Reference model state
  logic [3:0]             m_gpio_hist;
  int unsigned            m_count;
  logic                   m_gpio_out;
  logic                   m_pending;
  logic                   m_bus_err;
  data_t                  m_words [4];
  logic [NUM_DOMAINS-1:0] m_ack [ACK_LATENCY];

  ext_harness ext_harness_inst (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .reg_valid_i        (reg_valid),
    .reg_write_i        (reg_write),
    .reg_addr_i         (reg_addr),
    .reg_wdata_i        (reg_wdata),
    .reg_wstrb_i        (reg_wstrb),
    .reg_rdata_o        (reg_rdata),
    .reg_error_o        (reg_error),
    .gpio_i             (gpio_in),
    .gpio_o             (gpio_out),
    .intr_o             (intr),
    .pwr_switch_n_i     (pwr_switch_n),
    .pwr_switch_ack_n_o (pwr_switch_ack_n)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state ^ (rand_state >> 15);
  endfunction

  function automatic data_t expected_read(input addr_t addr);
    data_t value;
    value = '0;
    if (addr < SCRATCH_BASE) begin
      if (addr[7:0] == GPIO_CNT_COUNT) begin
        value = data_t'(m_count);
      end else if (addr[7:0] == GPIO_CNT_STATUS) begin
        value = data_t'(m_pending);
      end
    end else if (addr < UNMAPPED_BASE) begin
      value = m_words[addr[3:2]];
    end
    return value;
  endfunction

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("Mismatch on %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      fail_seen = 1'b1;
      $display("Test failures found");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Mismatch on %s: got 0x%h, expected 0x%h", name, actual, expected);
      fail_seen = 1'b1;
      $display("Test failures found");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic check_domains(input string name, input logic [NUM_DOMAINS-1:0] actual,
                               input logic [NUM_DOMAINS-1:0] expected);
    if (actual !== expected) begin
      $display("Mismatch on %s: got 0x%h, expected 0x%h", name, actual, expected);
      fail_seen = 1'b1;
      $display("Test failures found");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // Advance the model by one rising edge with the inputs of this cycle
  task automatic model_clock(input logic valid, input logic write, input addr_t addr,
                             input data_t wdata, input strb_t wstrb);
    logic edge_seen;
    logic wrap;
    // Count lands three edges after the first high sample
    edge_seen   = m_gpio_hist[2] && !m_gpio_hist[3];
    wrap        = edge_seen && (m_count == CNT_MAX - 1);
    m_gpio_hist = {m_gpio_hist[2:0], gpio_in};
    if (wrap) begin
      m_count    = 0;
      m_gpio_out = ~m_gpio_out;
      m_pending  = 1'b1;
    end else begin
      if (edge_seen) begin
        m_count++;
      end
      if (valid && write && addr == 32'h0000_0004 && wdata[0]) begin
        m_pending = 1'b0;
      end
    end
    if (valid && write && addr >= SCRATCH_BASE && addr < UNMAPPED_BASE) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb[b]) begin
          m_words[addr[3:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    m_bus_err = valid && (addr >= UNMAPPED_BASE);
    for (int s = ACK_LATENCY - 1; s > 0; s--) begin
      m_ack[s] = m_ack[s-1];
    end
    m_ack[0] = pwr_switch_n;
  endtask

  // Called on a falling edge, returns on the next one
  task automatic run_cycle(input logic valid, input logic write, input addr_t addr,
                           input data_t wdata, input strb_t wstrb);
    logic  exp_error;
    data_t exp_rdata;
    reg_valid    = valid;
    reg_write    = write;
    reg_addr     = addr;
    reg_wdata    = wdata;
    reg_wstrb    = wstrb;
    gpio_in      = gpio_level;
    pwr_switch_n = pwr_level;
    #(CLK_PERIOD / 4);
    exp_error = valid && (addr >= UNMAPPED_BASE);
    exp_rdata = (valid && !exp_error) ? expected_read(addr) : '0;
    check_data("reg_rdata_o", reg_rdata, exp_rdata);
    check_bit("reg_error_o", reg_error, exp_error);
    check_bit("gpio_o", gpio_out, m_gpio_out);
    check_bit("intr_o[INTR_GPIO_CNT]", intr[INTR_GPIO_CNT], m_pending);
    check_bit("intr_o[INTR_BUS_ERR]", intr[INTR_BUS_ERR], m_bus_err);
    check_domains("pwr_switch_ack_n_o", pwr_switch_ack_n, m_ack[ACK_LATENCY-1]);
    model_clock(valid, write, addr, wdata, wstrb);
    @(negedge clk);
  endtask

  initial begin
    #(CLK_PERIOD * MAX_CYCLES);
    $display("Timeout after %0d cycles, the test sequence did not complete", MAX_CYCLES);
    fail_seen = 1'b1;
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [31:0] r;
    rand_state   = 32'd8;
    fail_seen    = 1'b0;
    run_done     = 1'b0;
    rst_n        = 1'b0;
    reg_valid    = 1'b0;
    reg_write    = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    reg_wstrb    = '0;
    gpio_in      = 1'b0;
    pwr_switch_n = '1;
    gpio_level   = 1'b0;
    pwr_level    = '1;
    m_gpio_hist  = '0;
    m_count      = 0;
    m_gpio_out   = 1'b0;
    m_pending    = 1'b0;
    m_bus_err    = 1'b0;
    for (int w = 0; w < 4; w++) begin
      m_words[w] = '0;
    end
    for (int s = 0; s < ACK_LATENCY; s++) begin
      m_ack[s] = '1;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // State right after reset
    run_cycle(1'b1, 1'b0, GPIO_CNT_BASE, '0, '0);
    run_cycle(1'b1, 1'b0, GPIO_CNT_BASE + 4, '0, '0);
    for (int w = 0; w < 4; w++) begin
      run_cycle(1'b1, 1'b0, SCRATCH_BASE + addr_t'(4 * w), '0, '0);
    end

    // Scratch writes with random strobes, offsets alias
    for (int i = 0; i < SCRATCH_OPS; i++) begin
      r = next_rand();
      run_cycle(1'b1, 1'b1, SCRATCH_BASE + addr_t'(r[7:0]), next_rand(), r[11:8]);
      r = next_rand();
      run_cycle(1'b1, 1'b0, SCRATCH_BASE + addr_t'(r[7:0]), '0, '0);
    end

    // GPIO pulses, high then low for 4 to 7 cycles each
    for (int p = 0; p < GPIO_PULSES; p++) begin
      for (int level = 1; level >= 0; level--) begin
        gpio_level = level[0];
        repeat (4 + next_rand() % 4) begin
          r = next_rand();
          if (m_pending && r[3:0] == 4'h0) begin
            run_cycle(1'b1, 1'b1, GPIO_CNT_BASE + 4, 32'h1, '1);
          end else begin
            run_cycle(r[4], 1'b0, r[5] ? GPIO_CNT_BASE + 4 : GPIO_CNT_BASE, '0, '0);
          end
        end
      end
    end
    gpio_level = 1'b0;
    run_cycle(1'b1, 1'b1, GPIO_CNT_BASE + 4, 32'h1, '1);
    run_cycle(1'b1, 1'b0, GPIO_CNT_BASE + 4, '0, '0);

    // Unmapped accesses, each followed by a mapped read
    for (int i = 0; i < UNMAPPED_OPS; i++) begin
      r = next_rand();
      run_cycle(1'b1, r[31], r | UNMAPPED_BASE, next_rand(), r[3:0]);
      r = next_rand();
      run_cycle(1'b1, 1'b0, addr_t'(r[8:0]), '0, '0);
    end

    for (int i = 0; i < PWR_CYCLES; i++) begin
      r = next_rand();
      pwr_level = r[NUM_DOMAINS-1:0];
      run_cycle(1'b0, 1'b0, '0, '0, '0);
    end

    run_done = 1'b1;
    if (!fail_seen) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Catches a run stopped by a bound assertion
  final begin
    if (!run_done && !fail_seen) begin
      $display("Test failures found");
    end
  end

endmodule

//--- verilog.f
verilog/harness_pkg.sv
verilog/reg_demux.sv
verilog/gpio_cnt.sv
verilog/scratch_regs.sv
verilog/switch_ack_delay.sv
verilog/ext_harness.sv
testbench/ext_harness_chk.sv
testbench/tb_ext_harness.sv

//--- verilog/ext_harness.sv
/*
 * Harness peripheral subsystem: register bus demux, GPIO counter, scratch
 * registers, interrupt vector and power switch acknowledge model
 */
`timescale 1ns/10ps

module ext_harness #(
  parameter int unsigned CntMax           = 16,
  parameter int unsigned NumDomains       = 4,
  parameter int unsigned SwitchAckLatency = 15
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             reg_valid_i,
  input  logic                             reg_write_i,
  input  harness_pkg::addr_t               reg_addr_i,
  input  harness_pkg::data_t               reg_wdata_i,
  input  harness_pkg::strb_t               reg_wstrb_i,
  output harness_pkg::data_t               reg_rdata_o,
  output logic                             reg_error_o,
  input  logic                             gpio_i,
  output logic                             gpio_o,
  output logic [harness_pkg::NUM_INTR-1:0] intr_o,
  input  logic [NumDomains-1:0]            pwr_switch_n_i,
  output logic [NumDomains-1:0]            pwr_switch_ack_n_o
);

  import harness_pkg::*;

  logic       gpio_sel;
  logic       scratch_sel;
  logic       periph_write;
  logic [7:0] periph_offset;
  data_t      periph_wdata;
  strb_t      periph_wstrb;
  data_t      gpio_rdata;
  data_t      scratch_rdata;
  logic       gpio_intr;
  logic       bus_err_intr;

  reg_demux reg_demux_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reg_valid_i     (reg_valid_i),
    .reg_write_i     (reg_write_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_wstrb_i     (reg_wstrb_i),
    .reg_rdata_o     (reg_rdata_o),
    .reg_error_o     (reg_error_o),
    .gpio_sel_o      (gpio_sel),
    .scratch_sel_o   (scratch_sel),
    .periph_write_o  (periph_write),
    .periph_offset_o (periph_offset),
    .periph_wdata_o  (periph_wdata),
    .periph_wstrb_o  (periph_wstrb),
    .gpio_rdata_i    (gpio_rdata),
    .scratch_rdata_i (scratch_rdata),
    .bus_err_intr_o  (bus_err_intr)
  );

  gpio_cnt #(
    .CntMax (CntMax)
  ) gpio_cnt_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .gpio_i   (gpio_i),
    .sel_i    (gpio_sel),
    .write_i  (periph_write),
    .offset_i (periph_offset),
    .wdata_i  (periph_wdata),
    .rdata_o  (gpio_rdata),
    .gpio_o   (gpio_o),
    .intr_o   (gpio_intr)
  );

  scratch_regs scratch_regs_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sel_i    (scratch_sel),
    .write_i  (periph_write),
    .offset_i (periph_offset),
    .wdata_i  (periph_wdata),
    .wstrb_i  (periph_wstrb),
    .rdata_o  (scratch_rdata)
  );

  // Switch cell emulation for the external power domains
  switch_ack_delay #(
    .NumDomains       (NumDomains),
    .SwitchAckLatency (SwitchAckLatency)
  ) switch_ack_delay_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (pwr_switch_n_i),
    .ack_n_o    (pwr_switch_ack_n_o)
  );

  assign intr_o[INTR_GPIO_CNT] = gpio_intr;
  assign intr_o[INTR_BUS_ERR]  = bus_err_intr;

endmodule

//--- verilog/gpio_cnt.sv
/*
 * GPIO edge counter: counts synchronized rising edges, toggles the GPIO
 * output and raises a pending interrupt each time the count wraps
 */
`timescale 1ns/10ps

module gpio_cnt #(
  parameter int unsigned CntMax = 16
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               gpio_i,
  input  logic               sel_i,
  input  logic               write_i,
  input  logic [7:0]         offset_i,
  input  harness_pkg::data_t wdata_i,
  output harness_pkg::data_t rdata_o,
  output logic               gpio_o,
  output logic               intr_o
);

  import harness_pkg::*;

  localparam int unsigned CntW = (CntMax > 1) ? $clog2(CntMax) : 1;

  logic [1:0]      sync_q;
  logic            prev_q;
  logic            edge_q;
  logic [CntW-1:0] cnt_q;
  logic            gpio_q;
  logic            pending_q;
  logic            wrap;
  logic            clr_pending;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
      edge_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], gpio_i};
      prev_q <= sync_q[1];
      edge_q <= sync_q[1] & ~prev_q;
    end
  end

  assign wrap        = edge_q && (cnt_q == CntW'(CntMax - 1));
  assign clr_pending = sel_i && write_i && (offset_i == GPIO_CNT_STATUS) && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      gpio_q    <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q  <= '0;
        gpio_q <= ~gpio_q;
      end else if (edge_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // A new wrap wins over a clear
      if (wrap) begin
        pending_q <= 1'b1;
      end else if (clr_pending) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (offset_i)
      GPIO_CNT_COUNT:  rdata_o = data_t'(cnt_q);
      GPIO_CNT_STATUS: rdata_o = data_t'(pending_q);
      default:         rdata_o = '0;
    endcase
  end

  assign gpio_o = gpio_q;
  assign intr_o = pending_q;

endmodule

//--- verilog/harness_pkg.sv
/*
 * Harness package with bus widths, address map, peripheral indices,
 * register offsets and interrupt line numbers
 */
package harness_pkg;

  // Register bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Bus targets
  localparam int unsigned NUM_PERIPH = 2;

  typedef enum logic [0:0] {
    PERIPH_GPIO_CNT = 1'b0,
    PERIPH_SCRATCH  = 1'b1
  } periph_idx_e;

  // One fixed window per peripheral, everything from 0x200 up is unmapped
  localparam addr_t GPIO_CNT_BASE   = 32'h0000_0000;
  localparam addr_t SCRATCH_BASE    = 32'h0000_0100;
  localparam addr_t PERIPH_WIN_SIZE = 32'h0000_0100;

  // GPIO counter register offsets
  typedef enum logic [7:0] {
    GPIO_CNT_COUNT  = 8'h00,
    GPIO_CNT_STATUS = 8'h04
  } gpio_cnt_reg_e;

  // Interrupt vector
  localparam int unsigned NUM_INTR      = 2;
  localparam int unsigned INTR_GPIO_CNT = 0;
  localparam int unsigned INTR_BUS_ERR  = 1;

endpackage

//--- verilog/reg_demux.sv
/*
 * Register bus demux: decodes the address window, routes the access to one
 * peripheral and returns its read data or an error for unmapped addresses
 */
`timescale 1ns/10ps

module reg_demux (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  harness_pkg::addr_t reg_addr_i,
  input  harness_pkg::data_t reg_wdata_i,
  input  harness_pkg::strb_t reg_wstrb_i,
  output harness_pkg::data_t reg_rdata_o,
  output logic               reg_error_o,
  output logic               gpio_sel_o,
  output logic               scratch_sel_o,
  output logic               periph_write_o,
  output logic [7:0]         periph_offset_o,
  output harness_pkg::data_t periph_wdata_o,
  output harness_pkg::strb_t periph_wstrb_o,
  input  harness_pkg::data_t gpio_rdata_i,
  input  harness_pkg::data_t scratch_rdata_i,
  output logic               bus_err_intr_o
);

  import harness_pkg::*;

  periph_idx_e           periph_idx;
  logic                  addr_hit;
  logic [NUM_PERIPH-1:0] periph_sel;
  logic                  bus_err_q;

  // Window decode
  always_comb begin
    addr_hit   = 1'b0;
    periph_idx = PERIPH_GPIO_CNT;
    if (reg_addr_i >= GPIO_CNT_BASE && reg_addr_i < GPIO_CNT_BASE + PERIPH_WIN_SIZE) begin
      addr_hit   = 1'b1;
      periph_idx = PERIPH_GPIO_CNT;
    end else if (reg_addr_i >= SCRATCH_BASE &&
                 reg_addr_i < SCRATCH_BASE + PERIPH_WIN_SIZE) begin
      addr_hit   = 1'b1;
      periph_idx = PERIPH_SCRATCH;
    end
  end

  always_comb begin
    periph_sel = '0;
    if (reg_valid_i && addr_hit) begin
      periph_sel[periph_idx] = 1'b1;
    end
  end

  assign gpio_sel_o    = periph_sel[PERIPH_GPIO_CNT];
  assign scratch_sel_o = periph_sel[PERIPH_SCRATCH];

  // Windows are 0x100 aligned, so the low byte is the offset
  assign periph_write_o  = reg_write_i;
  assign periph_offset_o = reg_addr_i[7:0];
  assign periph_wdata_o  = reg_wdata_i;
  assign periph_wstrb_o  = reg_wstrb_i;

  always_comb begin
    reg_rdata_o = '0;
    if (reg_valid_i && addr_hit) begin
      case (periph_idx)
        PERIPH_GPIO_CNT: reg_rdata_o = gpio_rdata_i;
        PERIPH_SCRATCH:  reg_rdata_o = scratch_rdata_i;
        default:         reg_rdata_o = '0;
      endcase
    end
  end

  assign reg_error_o = reg_valid_i && !addr_hit;

  // One-cycle pulse after an unmapped access
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus_err_q <= 1'b0;
    end else begin
      bus_err_q <= reg_error_o;
    end
  end

  assign bus_err_intr_o = bus_err_q;

endmodule

//--- verilog/scratch_regs.sv
/*
 * Scratch register file of four words with byte strobe writes
 */
`timescale 1ns/10ps

module scratch_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sel_i,
  input  logic               write_i,
  input  logic [7:0]         offset_i,
  input  harness_pkg::data_t wdata_i,
  input  harness_pkg::strb_t wstrb_i,
  output harness_pkg::data_t rdata_o
);

  import harness_pkg::*;

  localparam int unsigned NumWords = 4;

  data_t      words_q [NumWords];
  logic [1:0] word_idx;

  // Offset bits above 3 are ignored, so the words alias
  assign word_idx = offset_i[3:2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < NumWords; w++) begin
        words_q[w] <= '0;
      end
    end else if (sel_i && write_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          words_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o = words_q[word_idx];

endmodule

//--- verilog/switch_ack_delay.sv
/*
 * Power switch model returning each domain's acknowledge a fixed number
 * of cycles after its switch request
 */
`timescale 1ns/10ps

module switch_ack_delay #(
  parameter int unsigned NumDomains       = 4,
  parameter int unsigned SwitchAckLatency = 15
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [NumDomains-1:0] switch_n_i,
  output logic [NumDomains-1:0] ack_n_o
);

  logic [NumDomains-1:0] stage_q [SwitchAckLatency];

  // Active low, so all ones means switched off and not acknowledged
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < SwitchAckLatency; s++) begin
        stage_q[s] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int s = 1; s < SwitchAckLatency; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign ack_n_o = stage_q[SwitchAckLatency-1];

endmodule
